/* source/i2c_pkg.sv */
package i2c_pkg;

    // command opcodes, always in the top two bits of a command word
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } i2c_op_e;

    // one command word, decoded either as a write or as a read
    typedef union packed {
        // write view holds the opcode and the byte to send
        struct packed {
            i2c_op_e    op;
            logic [7:0] data;
        } wr;
        // read view holds the opcode, the last flag and unused bits
        // last asks for a nack after the byte
        struct packed {
            i2c_op_e    op;
            logic       last;
            logic [6:0] rsvd;
        } rd;
    } i2c_cmd_u;

    // width of a command word as stored in the FIFO
    localparam int CMD_W = $bits(i2c_cmd_u);

endpackage

/* source/i2c_bit_if.sv */
`timescale 1ns/1ps

interface i2c_bit_if;

    // requests from the byte generator
    logic req;
    logic we;
    logic wr_bit;

    // status and sampled data from the bit generator
    logic ready;
    logic rd_valid;
    logic rd_bit;

    modport byte_side (output req, output we, output wr_bit,
                       input ready, input rd_valid, input rd_bit);

    modport bit_side (input req, input we, input wr_bit,
                      output ready, output rd_valid, output rd_bit);

endinterface

/* source/i2c_cmd_fifo.sv */
`timescale 1ns/1ps

module i2c_cmd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_push,
    input  logic                       i_pop,
    input  logic [i2c_pkg::CMD_W-1:0]  i_wdata,
    output logic [i2c_pkg::CMD_W-1:0]  o_rdata,
    output logic                       o_full,
    output logic                       o_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [i2c_pkg::CMD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [PTR_W:0]            count;
    logic                      do_push;
    logic                      do_pop;

    assign o_full  = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign o_empty = (count == '0);

    // pushes into a full buffer are dropped here
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    // storage and read word
    // the word shows up the cycle after the pop
    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_wdata;
        end
        if (do_pop) begin
            o_rdata <= mem[rd_ptr];
        end
    end

endmodule

/* source/i2c_sequencer.sv */
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic              i_clk,
    input  logic              i_rst,
    input  i2c_pkg::i2c_cmd_u i_cmd,
    input  logic              i_cmd_empty,
    output logic              o_cmd_pop,
    output logic              o_start_req,
    output logic              o_stop_req,
    output logic              o_byte_req,
    output logic              o_byte_we,
    output logic [7:0]        o_wr_byte,
    output logic              o_rd_last,
    input  logic              i_bit_ready,
    input  logic              i_byte_ready,
    output logic              o_idle
);

    import i2c_pkg::*;

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_DISPATCH = 2'd1;
    localparam logic [1:0] S_GAP      = 2'd2;

    logic [1:0] state;
    logic       is_bit_op;
    logic       target_ready;
    logic       fire;

    // both views carry the opcode in the same place
    assign is_bit_op    = (i_cmd.wr.op == OP_START) | (i_cmd.wr.op == OP_STOP);
    assign target_ready = is_bit_op ? i_bit_ready : i_byte_ready;
    assign fire         = (state == S_DISPATCH) & target_ready;

    // only fetch when nothing downstream is still working
    assign o_cmd_pop = (state == S_IDLE) & ~i_cmd_empty & i_bit_ready & i_byte_ready;
    assign o_idle    = (state == S_IDLE);

    assign o_start_req = fire & (i_cmd.wr.op == OP_START);
    assign o_stop_req  = fire & (i_cmd.wr.op == OP_STOP);
    assign o_byte_req  = fire & ~is_bit_op;
    assign o_byte_we   = (i_cmd.wr.op == OP_WRITE);
    assign o_wr_byte   = i_cmd.wr.data;
    assign o_rd_last   = i_cmd.rd.last;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (o_cmd_pop) begin
                        state <= S_DISPATCH;
                    end
                end
                S_DISPATCH: begin
                    if (fire) begin
                        state <= S_GAP;
                    end
                end
                // ready of the target drops one cycle after the strobe
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

/* source/i2c_byte_gen.sv */
`timescale 1ns/1ps

module i2c_byte_gen (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_req,
    input  logic       i_we,
    input  logic [7:0] i_wr_byte,
    // sends a nack on the ninth bit when set
    input  logic       i_rd_last,
    output logic       o_ready,
    output logic       o_wr_ack,
    output logic       o_wr_nack,
    output logic       o_rd_valid,
    output logic [7:0] o_rd_byte,
    i2c_bit_if.byte_side bit_if
);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_BIT_REQ = 3'd1;
    localparam logic [2:0] S_WAIT    = 3'd2;
    localparam logic [2:0] S_LOAD    = 3'd3;
    localparam logic [2:0] S_DONE    = 3'd4;

    logic [2:0] state;
    logic       write_en;
    logic       rd_last;
    logic [7:0] shift;
    logic [3:0] bit_cnt;
    logic       samp_bit;
    logic       data_phase;

    // bits 0..7 carry data, bit 8 is the ack slot
    assign data_phase = (bit_cnt < 4'd8);

    // masked by the bit generator so a new byte never starts mid bit
    assign o_ready = (state == S_IDLE) & bit_if.ready;

    // ack is a low level on sda
    assign o_wr_ack   = (state == S_DONE) & write_en & ~samp_bit;
    assign o_wr_nack  = (state == S_DONE) & write_en & samp_bit;
    assign o_rd_valid = (state == S_DONE) & ~write_en;
    assign o_rd_byte  = shift;

    assign bit_if.req = (state == S_BIT_REQ);
    // direction flips for the ack slot
    assign bit_if.we     = data_phase ~^ write_en;
    assign bit_if.wr_bit = data_phase ? shift[7] : rd_last;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= S_IDLE;
            write_en <= 1'b0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_req & bit_if.ready) begin
                        state    <= S_BIT_REQ;
                        write_en <= i_we;
                        bit_cnt  <= '0;
                    end
                end
                S_BIT_REQ: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    // rd_valid always arrives before ready comes back
                    if (!bit_if.rd_valid && bit_if.ready) begin
                        state <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (data_phase) begin
                        state <= S_BIT_REQ;
                    end else begin
                        state <= S_DONE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // byte shifter and sampled bit
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_req && bit_if.ready) begin
            rd_last  <= i_rd_last;
            shift    <= i_we ? i_wr_byte : 8'h00;
            samp_bit <= 1'b0;
        end else if (state == S_WAIT && bit_if.rd_valid) begin
            samp_bit <= bit_if.rd_bit;
        end else if (state == S_LOAD && data_phase) begin
            // msb first, read-back bit enters at the bottom
            shift <= {shift[6:0], samp_bit};
        end
    end

endmodule

/* source/i2c_bit_gen.sv */
`timescale 1ns/1ps

module i2c_bit_gen #(
    parameter int CLK_FREQ = 16_000_000,
    parameter int I2C_FREQ = 1_000_000
) (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_start_req,
    input  logic i_stop_req,
    i2c_bit_if.bit_side bit_if,
    output logic o_scl,
    output logic o_sda_low,
    input  logic i_sda
);

    // cycles per quarter of an scl period
    localparam int QUARTER = CLK_FREQ / (4 * I2C_FREQ);
    localparam int CNT_W   = (QUARTER > 1) ? $clog2(QUARTER) : 1;

    localparam logic [1:0] K_START = 2'd0;
    localparam logic [1:0] K_STOP  = 2'd1;
    localparam logic [1:0] K_DATA  = 2'd2;

    logic             busy;
    logic [1:0]       kind;
    logic [1:0]       quarter;
    logic [CNT_W-1:0] tick;
    logic             drive_low;
    logic             accept;
    logic             quarter_end;
    logic             load;
    logic [1:0]       kind_sel;
    logic [1:0]       quarter_sel;
    logic             drive_sel;
    logic             scl_d;
    logic             sda_low_d;

    assign accept      = ~busy & (i_start_req | i_stop_req | bit_if.req);
    assign quarter_end = busy & (tick == CNT_W'(QUARTER - 1));
    // new bus levels at the start of every quarter
    assign load        = accept | (quarter_end & (quarter != 2'd3));

    assign bit_if.ready = ~busy;

    // bus levels for the quarter that is about to begin
    always_comb begin
        kind_sel    = kind;
        quarter_sel = quarter + 2'd1;
        drive_sel   = drive_low;
        if (accept) begin
            quarter_sel = 2'd0;
            drive_sel   = bit_if.we & ~bit_if.wr_bit;
            if (i_start_req) begin
                kind_sel = K_START;
            end else if (i_stop_req) begin
                kind_sel = K_STOP;
            end else begin
                kind_sel = K_DATA;
            end
        end

        scl_d     = o_scl;
        sda_low_d = o_sda_low;
        case (kind_sel)
            K_START: begin
                // release sda first so a repeated start from scl low works
                case (quarter_sel)
                    2'd0: sda_low_d = 1'b0;
                    2'd1: scl_d = 1'b1;
                    2'd2: sda_low_d = 1'b1;
                    default: scl_d = 1'b0;
                endcase
            end
            K_STOP: begin
                case (quarter_sel)
                    2'd0: scl_d = 1'b0;
                    2'd1: sda_low_d = 1'b1;
                    2'd2: scl_d = 1'b1;
                    default: sda_low_d = 1'b0;
                endcase
            end
            default: begin
                // data changes only while scl is low
                case (quarter_sel)
                    2'd0: sda_low_d = drive_sel;
                    2'd1: scl_d = 1'b1;
                    2'd2: scl_d = 1'b1;
                    default: scl_d = 1'b0;
                endcase
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy            <= 1'b0;
            kind            <= K_DATA;
            quarter         <= '0;
            tick            <= '0;
            o_scl           <= 1'b1;
            o_sda_low       <= 1'b0;
            bit_if.rd_valid <= 1'b0;
        end else begin
            bit_if.rd_valid <= quarter_end & (quarter == 2'd1) & (kind == K_DATA);
            if (load) begin
                o_scl     <= scl_d;
                o_sda_low <= sda_low_d;
            end
            if (accept) begin
                busy    <= 1'b1;
                kind    <= kind_sel;
                quarter <= 2'd0;
                tick    <= '0;
            end else if (busy) begin
                tick <= quarter_end ? '0 : tick + 1'b1;
                if (quarter_end) begin
                    quarter <= quarter + 2'd1;
                    // ready returns right after the last quarter
                    if (quarter == 2'd3) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            drive_low <= drive_sel;
        end
        // sample sda at the end of the first scl high quarter
        if (quarter_end && quarter == 2'd1) begin
            bit_if.rd_bit <= i_sda;
        end
    end

endmodule

/* source/i2c_master_top.sv */
`timescale 1ns/1ps

module i2c_master_top #(
    parameter int CLK_FREQ   = 16_000_000,
    parameter int I2C_FREQ   = 1_000_000,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_cmd_push,
    input  logic [i2c_pkg::CMD_W-1:0] i_cmd,
    output logic                      o_cmd_full,
    output logic                      o_wr_ack,
    output logic                      o_wr_nack,
    output logic                      o_rd_valid,
    output logic [7:0]                o_rd_byte,
    output logic                      o_busy,
    output logic                      o_scl,
    output logic                      o_sda_low,
    input  logic                      i_sda
);

    import i2c_pkg::*;

    i2c_cmd_u   fifo_word;
    logic       fifo_empty;
    logic       cmd_pop;
    logic       start_req;
    logic       stop_req;
    logic       byte_req;
    logic       byte_we;
    logic [7:0] wr_byte;
    logic       rd_last;
    logic       byte_ready;
    logic       seq_idle;

    i2c_bit_if bit_bus ();

    i2c_cmd_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i2c_cmd_fifo_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_push(i_cmd_push), .i_pop(cmd_pop),
        .i_wdata(i_cmd), .o_rdata(fifo_word),
        .o_full(o_cmd_full), .o_empty(fifo_empty)
    );

    i2c_sequencer i2c_sequencer_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_cmd(fifo_word), .i_cmd_empty(fifo_empty), .o_cmd_pop(cmd_pop),
        .o_start_req(start_req), .o_stop_req(stop_req),
        .o_byte_req(byte_req), .o_byte_we(byte_we),
        .o_wr_byte(wr_byte), .o_rd_last(rd_last),
        .i_bit_ready(bit_bus.ready), .i_byte_ready(byte_ready),
        .o_idle(seq_idle)
    );

    i2c_byte_gen i2c_byte_gen_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_req(byte_req), .i_we(byte_we), .i_wr_byte(wr_byte), .i_rd_last(rd_last),
        .o_ready(byte_ready), .o_wr_ack(o_wr_ack), .o_wr_nack(o_wr_nack),
        .o_rd_valid(o_rd_valid), .o_rd_byte(o_rd_byte),
        .bit_if(bit_bus.byte_side)
    );

    i2c_bit_gen #(
        .CLK_FREQ(CLK_FREQ),
        .I2C_FREQ(I2C_FREQ)
    ) i2c_bit_gen_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start_req(start_req), .i_stop_req(stop_req),
        .bit_if(bit_bus.bit_side),
        .o_scl(o_scl), .o_sda_low(o_sda_low), .i_sda(i_sda)
    );

    // busy while anything is queued or any stage is still working
    assign o_busy = ~fifo_empty | ~seq_idle | ~byte_ready | ~bit_bus.ready;

endmodule

/* testbench/i2c_bit_gen_assertions.sv */
`timescale 1ns/1ps

module i2c_bit_gen_assertions (
    input logic i_clk,
    input logic i_rst,
    input logic i_scl,
    input logic i_sda_low,
    input logic i_data_bit,
    input logic i_ready,
    input logic i_req,
    input logic i_start_req,
    input logic i_stop_req,
    input logic i_rd_valid
);

    // count of failed assertions
    int failures = 0;

    // under a high scl only start and stop may move sda
    sda_stable_in_data: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_scl && $past(i_scl) && $changed(i_sda_low)) |-> !i_data_bit)
        else begin
            failures++;
            $error("sda changed while scl was high during a data bit");
        end

    rd_valid_while_busy: assert property (@(posedge i_clk) disable iff (i_rst)
        i_rd_valid |-> !i_ready)
        else begin
            failures++;
            $error("rd_valid pulsed while the bit generator was idle");
        end

    req_only_when_ready: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_req || i_start_req || i_stop_req) |-> i_ready)
        else begin
            failures++;
            $error("a request reached the bit generator while it was busy");
        end

endmodule

bind i2c_bit_gen i2c_bit_gen_assertions i2c_bit_gen_assertions_inst (
    .i_clk(i_clk),
    .i_rst(i_rst),
    .i_scl(o_scl),
    .i_sda_low(o_sda_low),
    .i_data_bit(kind == K_DATA),
    .i_ready(bit_if.ready),
    .i_req(bit_if.req),
    .i_start_req(i_start_req),
    .i_stop_req(i_stop_req),
    .i_rd_valid(bit_if.rd_valid)
);

/* testbench/tb_i2c_master.sv */
`timescale 1ns/1ps

module tb_i2c_master;

    import i2c_pkg::*;

    localparam int CLK_FREQ   = 16_000_000;
    localparam int I2C_FREQ   = 1_000_000;
    localparam int FIFO_DEPTH = 8;
    // commands issued over all tests
    localparam int TOTAL_CMDS  = 21;
    localparam int WATCHDOG_NS = TOTAL_CMDS * 40 * 4 * 8 * 2;

    logic             clk = 1'b0;
    logic             rst;
    logic             cmd_push;
    logic [CMD_W-1:0] cmd;
    logic             cmd_full;
    logic             wr_ack;
    logic             wr_nack;
    logic             rd_valid;
    logic [7:0]       rd_byte;
    logic             busy;
    logic             scl;
    logic             sda_low;
    logic             sda;

    // slave model state
    logic       slave_low = 1'b0;
    logic       slave_nack = 1'b0;
    logic       scl_q;
    logic       sda_q;
    logic       busy_q;
    logic       in_frame;
    logic       read_frame;
    logic       rd_active;
    logic [7:0] rx_byte;
    int         bit_idx;
    int         rd_idx = 0;
    logic [7:0] rd_table [8];
    // one entry per frame, 1 makes the slave send data
    logic       frame_modes [$];
    logic [7:0] wr_seen [$];
    logic [7:0] rd_seen [$];
    logic       ack_seen [$];

    int          start_count = 0;
    int          stop_count = 0;
    int          ack_count = 0;
    int          nack_count = 0;
    int          busy_falls = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          assert_failures;
    logic [31:0] lfsr_state = 32'hd24c_6557;

    i2c_master_top #(
        .CLK_FREQ(CLK_FREQ),
        .I2C_FREQ(I2C_FREQ),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i2c_master_top_inst (
        .i_clk(clk), .i_rst(rst),
        .i_cmd_push(cmd_push), .i_cmd(cmd), .o_cmd_full(cmd_full),
        .o_wr_ack(wr_ack), .o_wr_nack(wr_nack),
        .o_rd_valid(rd_valid), .o_rd_byte(rd_byte), .o_busy(busy),
        .o_scl(scl), .o_sda_low(sda_low), .i_sda(sda)
    );

    // open drain bus with pull-up
    assign sda = ~(sda_low | slave_low);

    always #4 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: the tests did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    function automatic logic [CMD_W-1:0] cmd_word(i2c_op_e op, logic [7:0] data);
        i2c_cmd_u c;
        c.wr.op   = op;
        c.wr.data = data;
        return c;
    endfunction

    function automatic logic [CMD_W-1:0] read_cmd(logic last);
        i2c_cmd_u c;
        c.rd.op   = OP_READ;
        c.rd.last = last;
        c.rd.rsvd = '0;
        return c;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_bus_idle(string name);
        check_value({name, " scl"}, 1, scl);
        check_value({name, " sda"}, 1, sda);
    endtask

    task automatic push_cmd(logic [CMD_W-1:0] word);
        cmd      = word;
        cmd_push = 1'b1;
        @(negedge clk);
        cmd_push = 1'b0;
    endtask

    // busy is already up one edge after a push
    task automatic wait_idle();
        while (busy) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic clear_records(logic nack);
        slave_nack  = nack;
        rd_idx      = 0;
        start_count = 0;
        stop_count  = 0;
        ack_count   = 0;
        nack_count  = 0;
        busy_falls  = 0;
        frame_modes.delete();
        wr_seen.delete();
        rd_seen.delete();
        ack_seen.delete();
    endtask

    // slave model reacts to the bus half a cycle after the master moves it
    always @(negedge clk) begin
        if (rst) begin
            slave_low = 1'b0;
            in_frame  = 1'b0;
        end else if (scl && scl_q && sda_q && !sda) begin
            start_count++;
            in_frame   = 1'b1;
            bit_idx    = 0;
            rx_byte    = '0;
            read_frame = 1'b0;
            if (frame_modes.size() > 0) begin
                read_frame = frame_modes.pop_front();
            end
            rd_active = read_frame;
        end else if (scl && scl_q && !sda_q && sda) begin
            stop_count++;
            in_frame  = 1'b0;
            slave_low = 1'b0;
        end else if (in_frame && scl && !scl_q) begin
            if (bit_idx < 8) begin
                rx_byte = {rx_byte[6:0], sda};
            end else if (read_frame) begin
                ack_seen.push_back(sda);
                rd_idx++;
                rd_active = !sda;
            end else begin
                wr_seen.push_back(rx_byte);
            end
            bit_idx = (bit_idx == 8) ? 0 : bit_idx + 1;
        end else if (in_frame && !scl && scl_q) begin
            if (read_frame) begin
                slave_low = rd_active && (bit_idx < 8) && !rd_table[rd_idx][7 - bit_idx];
            end else begin
                slave_low = (bit_idx == 8) && !slave_nack;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

    // master side results
    always @(negedge clk) begin
        if (!rst) begin
            if (wr_ack) begin
                ack_count++;
            end
            if (wr_nack) begin
                nack_count++;
            end
            if (rd_valid) begin
                rd_seen.push_back(rd_byte);
            end
            if (busy_q && !busy) begin
                busy_falls++;
            end
        end
        busy_q = busy;
    end

    task automatic run_write(string name, logic nack);
        logic [7:0] data;
        data = random_byte();
        clear_records(nack);
        frame_modes.push_back(1'b0);
        push_cmd(cmd_word(OP_START, 8'h00));
        push_cmd(cmd_word(OP_WRITE, data));
        push_cmd(cmd_word(OP_STOP, 8'h00));
        wait_idle();
        check_value({name, " bytes"}, 1, wr_seen.size());
        if (wr_seen.size() > 0) begin
            check_value({name, " data"}, data, wr_seen[0]);
        end
        check_value({name, " ack"}, nack ? 0 : 1, ack_count);
        check_value({name, " nack"}, nack ? 1 : 0, nack_count);
        check_value({name, " starts"}, 1, start_count);
        check_value({name, " stops"}, 1, stop_count);
        check_bus_idle(name);
    endtask

    task automatic test_write_ack();
        run_write("write_ack", 1'b0);
    endtask

    task automatic test_write_nack();
        run_write("write_nack", 1'b1);
    endtask

    task automatic test_read_sequence();
        clear_records(1'b0);
        frame_modes.push_back(1'b1);
        push_cmd(cmd_word(OP_START, 8'h00));
        push_cmd(read_cmd(1'b0));
        push_cmd(read_cmd(1'b1));
        push_cmd(cmd_word(OP_STOP, 8'h00));
        wait_idle();
        check_value("read bytes", 2, rd_seen.size());
        check_value("read acks", 2, ack_seen.size());
        if (rd_seen.size() == 2 && ack_seen.size() == 2) begin
            check_value("read byte 0", rd_table[0], rd_seen[0]);
            check_value("read byte 1", rd_table[1], rd_seen[1]);
            check_value("read ack after byte 0", 0, ack_seen[0]);
            check_value("read nack after byte 1", 1, ack_seen[1]);
        end
        check_value("read stops", 1, stop_count);
        check_bus_idle("read");
    endtask

    task automatic test_bus_framing();
        clear_records(1'b0);
        frame_modes.push_back(1'b0);
        push_cmd(cmd_word(OP_START, 8'h00));
        push_cmd(cmd_word(OP_STOP, 8'h00));
        wait_idle();
        check_value("framing starts", 1, start_count);
        check_value("framing stops", 1, stop_count);
        check_value("framing bytes", 0, wr_seen.size());
        check_bus_idle("framing");
    endtask

    task automatic test_buffering();
        logic [7:0] data [3];
        for (int i = 0; i < 3; i++) begin
            data[i] = random_byte();
        end
        clear_records(1'b0);
        frame_modes.push_back(1'b0);
        frame_modes.push_back(1'b1);
        // the first word goes straight to the sequencer and the other eight fill the FIFO
        push_cmd(cmd_word(OP_START, 8'h00));
        for (int i = 0; i < 3; i++) begin
            push_cmd(cmd_word(OP_WRITE, data[i]));
        end
        push_cmd(cmd_word(OP_STOP, 8'h00));
        push_cmd(cmd_word(OP_START, 8'h00));
        push_cmd(read_cmd(1'b0));
        push_cmd(read_cmd(1'b1));
        push_cmd(cmd_word(OP_STOP, 8'h00));
        check_value("buffering full", 1, cmd_full);
        check_value("buffering bytes before drain", 0, wr_seen.size());
        wait_idle();
        check_value("buffering written", 3, wr_seen.size());
        check_value("buffering read", 2, rd_seen.size());
        if (wr_seen.size() == 3 && rd_seen.size() == 2) begin
            for (int i = 0; i < 3; i++) begin
                check_value($sformatf("buffering write %0d", i), data[i], wr_seen[i]);
            end
            check_value("buffering read 0", rd_table[0], rd_seen[0]);
            check_value("buffering read 1", rd_table[1], rd_seen[1]);
        end
        check_value("buffering acks", 3, ack_count);
        check_value("buffering starts", 2, start_count);
        check_value("buffering stops", 2, stop_count);
        check_value("buffering busy falls", 1, busy_falls);
        check_bus_idle("buffering");
    endtask

    initial begin
        rst      = 1'b1;
        cmd_push = 1'b0;
        cmd      = '0;
        for (int i = 0; i < 8; i++) begin
            rd_table[i] = random_byte();
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("reset busy", 0, busy);
        check_bus_idle("reset");

        test_write_ack();
        test_write_nack();
        test_read_sequence();
        test_bus_framing();
        test_buffering();

        assert_failures = i2c_master_top_inst.i2c_bit_gen_inst.i2c_bit_gen_assertions_inst.failures;
        $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
source/i2c_pkg.sv
source/i2c_bit_if.sv
source/i2c_cmd_fifo.sv
source/i2c_sequencer.sv
source/i2c_byte_gen.sv
source/i2c_bit_gen.sv
source/i2c_master_top.sv
testbench/i2c_bit_gen_assertions.sv
testbench/tb_i2c_master.sv

/* Bender.yml */
package:
  name: i2c_master

sources:
  - files:
      - source/i2c_pkg.sv
      - source/i2c_bit_if.sv
      - source/i2c_cmd_fifo.sv
      - source/i2c_sequencer.sv
      - source/i2c_byte_gen.sv
      - source/i2c_bit_gen.sv
      - source/i2c_master_top.sv
  - target: test
    files:
      - testbench/i2c_bit_gen_assertions.sv
      - testbench/tb_i2c_master.sv
